// ==== capture_pkg.sv ====
`default_nettype none

package capture_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int DATA_W     = 16;
  localparam int ADDR_W     = 16;
  localparam int BUF_ADDR_W = 12;
  localparam int TS_W       = 32;
  localparam int LEN_W      = 12;
  localparam int STATUS_W   = 4;

  // --------------------
  // Address map
  // --------------------
  // Frame byte 0 lands here, words below sit under the register window
  localparam logic [BUF_ADDR_W-1:0] BUF_BASE_WORD = 12'd8;

  // Address bits 15:13
  typedef enum logic [2:0] {
    REGION_GLOBAL = 3'd0,
    REGION_RX1    = 3'd4
  } region_e;

  // Byte offsets inside a region
  localparam logic [2:0] OFS_STATUS = 3'd0;
  localparam logic [2:0] OFS_CNT_LO = 3'd2;
  localparam logic [2:0] OFS_CNT_HI = 3'd4;
  localparam logic [2:0] OFS_TS_LO  = 3'd0;
  localparam logic [2:0] OFS_TS_HI  = 3'd2;
  localparam logic [2:0] OFS_LEN    = 3'd4;

  // Bits 12:3 all zero selects the registers
  localparam int REG_WINDOW_W = 10;

  // Slot status bits
  localparam int STAT_READY_BIT = 0;
  localparam int STAT_ARM_BIT   = 1;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_WAIT_GAP,
    RX_LOAD,
    RX_DONE
  } rx_state_e;

  typedef enum logic [1:0] {
    HB_IDLE,
    HB_MEM_ADDR,
    HB_MEM_WAIT,
    HB_ACK
  } host_state_e;

endpackage

`default_nettype wire

// ==== eth_rx_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_rx_capture (
  input  wire                                clk_125,
  input  wire                                core_rst_n,
  input  wire                                armed_i,
  input  wire  [capture_pkg::TS_W-1:0]       global_cnt_i,
  input  wire                                rx_dv_i,
  input  wire  [7:0]                         rx_data_i,
  output logic                               frame_done_o,
  output logic                               rx_busy_o,
  output logic                               buf_we_o,
  output logic [capture_pkg::BUF_ADDR_W-1:0] buf_addr_o,
  output logic [1:0]                         buf_be_o,
  output logic [capture_pkg::DATA_W-1:0]     buf_wdata_o,
  output logic [capture_pkg::TS_W-1:0]       rx_timestamp_o,
  output logic [capture_pkg::LEN_W-1:0]      rx_frame_len_o
);

  capture_pkg::rx_state_e          state;
  logic [capture_pkg::LEN_W-1:0]   byte_cnt;
  logic                            byte_valid;

  assign byte_valid   = (state == capture_pkg::RX_LOAD) && rx_dv_i;
  assign frame_done_o = (state == capture_pkg::RX_DONE);
  assign rx_busy_o    = (state == capture_pkg::RX_LOAD);

  // --------------------
  // Receive FSM
  // --------------------
  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      state          <= capture_pkg::RX_IDLE;
      byte_cnt       <= '0;
      buf_we_o       <= 1'b0;
      rx_timestamp_o <= '0;
      rx_frame_len_o <= '0;
    end else begin
      buf_we_o <= 1'b0;
      case (state)
        capture_pkg::RX_IDLE: begin
          byte_cnt <= '0;
          if (armed_i) begin
            state <= capture_pkg::RX_WAIT_GAP;
          end
        end
        // Never start in the middle of a frame
        capture_pkg::RX_WAIT_GAP: begin
          if (!armed_i) begin
            state <= capture_pkg::RX_IDLE;
          end else if (!rx_dv_i) begin
            state <= capture_pkg::RX_LOAD;
          end
        end
        capture_pkg::RX_LOAD: begin
          if (rx_dv_i) begin
            buf_we_o <= 1'b1;
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == '0) begin
              rx_timestamp_o <= global_cnt_i;
            end
          end else if (byte_cnt != '0) begin
            state <= capture_pkg::RX_DONE;
          end
        end
        capture_pkg::RX_DONE: begin
          rx_frame_len_o <= byte_cnt;
          state          <= capture_pkg::RX_IDLE;
        end
        default: begin
          state <= capture_pkg::RX_IDLE;
        end
      endcase
    end
  end

  // Even bytes go low, odd bytes go high
  always_ff @(posedge clk_125) begin
    if (byte_valid) begin
      buf_addr_o  <= capture_pkg::BUF_BASE_WORD +
                     capture_pkg::BUF_ADDR_W'(byte_cnt[capture_pkg::LEN_W-1:1]);
      buf_be_o    <= byte_cnt[0] ? 2'b10 : 2'b01;
      buf_wdata_o <= {rx_data_i, rx_data_i};
    end
  end

endmodule

`default_nettype wire

// ==== frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
  input  wire                                clk_125,
  // Host side
  input  wire  [capture_pkg::BUF_ADDR_W-1:0] a_addr_i,
  input  wire                                a_we_i,
  input  wire  [1:0]                         a_be_i,
  input  wire  [capture_pkg::DATA_W-1:0]     a_wdata_i,
  output logic [capture_pkg::DATA_W-1:0]     a_rdata_o,
  // Receiver side, write only
  input  wire  [capture_pkg::BUF_ADDR_W-1:0] b_addr_i,
  input  wire                                b_we_i,
  input  wire  [1:0]                         b_be_i,
  input  wire  [capture_pkg::DATA_W-1:0]     b_wdata_i
);

  logic [capture_pkg::DATA_W-1:0] mem [0:(2**capture_pkg::BUF_ADDR_W)-1];

  // --------------------
  // Byte lane writes
  // --------------------
  // port B wins if both hit the same byte
  always_ff @(posedge clk_125) begin
    for (int i = 0; i < capture_pkg::DATA_W / 8; i++) begin
      if (a_we_i && a_be_i[i]) begin
        mem[a_addr_i][8*i +: 8] <= a_wdata_i[8*i +: 8];
      end
      if (b_we_i && b_be_i[i]) begin
        mem[b_addr_i][8*i +: 8] <= b_wdata_i[8*i +: 8];
      end
    end
  end

  // One cycle read latency
  always_ff @(posedge clk_125) begin
    a_rdata_o <= mem[a_addr_i];
  end

endmodule

`default_nettype wire

// ==== global_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module global_regs (
  input  wire                              clk_125,
  input  wire                              core_rst_n,
  input  wire                              frame_done_i,
  input  wire                              stat_we_i,
  input  wire                              cnt_lo_we_i,
  input  wire                              cnt_hi_we_i,
  input  wire  [1:0]                       sel_i,
  input  wire  [capture_pkg::DATA_W-1:0]   wdata_i,
  output logic [capture_pkg::STATUS_W-1:0] status_o,
  output logic [capture_pkg::TS_W-1:0]     global_cnt_o,
  output logic                             armed_o,
  output logic                             irq_o
);

  // --------------------
  // Slot status
  // --------------------
  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      status_o <= '0;
    end else if (frame_done_i) begin
      status_o[capture_pkg::STAT_READY_BIT] <= 1'b1;
      status_o[capture_pkg::STAT_ARM_BIT]   <= 1'b0;
    end else if (stat_we_i && sel_i[0]) begin
      status_o <= wdata_i[capture_pkg::STATUS_W-1:0];
    end
  end

  assign armed_o = status_o[capture_pkg::STAT_ARM_BIT];
  assign irq_o   = status_o[capture_pkg::STAT_READY_BIT];

  // --------------------
  // Global counter
  // --------------------
  // A write loads the selected bytes and skips the increment
  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      global_cnt_o <= '0;
    end else if (cnt_lo_we_i || cnt_hi_we_i) begin
      for (int b = 0; b < 2; b++) begin
        if (sel_i[b] && cnt_lo_we_i) begin
          global_cnt_o[8*b +: 8] <= wdata_i[8*b +: 8];
        end
        if (sel_i[b] && cnt_hi_we_i) begin
          global_cnt_o[capture_pkg::DATA_W + 8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end else begin
      global_cnt_o <= global_cnt_o + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== host_bus_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_bus_decoder (
  input  wire                                clk_125,
  input  wire                                core_rst_n,
  // Host bus
  input  wire                                wb_cyc_i,
  input  wire                                wb_stb_i,
  input  wire                                wb_we_i,
  input  wire  [capture_pkg::ADDR_W-1:0]     wb_adr_i,
  input  wire  [1:0]                         wb_sel_i,
  input  wire  [capture_pkg::DATA_W-1:0]     wb_dat_i,
  output logic [capture_pkg::DATA_W-1:0]     wb_dat_o,
  output logic                               wb_ack_o,
  // Global registers
  output logic                               stat_we_o,
  output logic                               cnt_lo_we_o,
  output logic                               cnt_hi_we_o,
  output logic [1:0]                         sel_o,
  output logic [capture_pkg::DATA_W-1:0]     wdata_o,
  input  wire  [capture_pkg::STATUS_W-1:0]   status_i,
  input  wire  [capture_pkg::TS_W-1:0]       global_cnt_i,
  // Receive slot
  input  wire  [capture_pkg::TS_W-1:0]       rx_timestamp_i,
  input  wire  [capture_pkg::LEN_W-1:0]      rx_frame_len_i,
  // Frame buffer port A
  output logic [capture_pkg::BUF_ADDR_W-1:0] a_addr_o,
  output logic                               a_we_o,
  output logic [1:0]                         a_be_o,
  output logic [capture_pkg::DATA_W-1:0]     a_wdata_o,
  input  wire  [capture_pkg::DATA_W-1:0]     a_rdata_i
);

  capture_pkg::host_state_e       state;
  capture_pkg::region_e           region;
  logic                           in_window;
  logic [2:0]                     reg_ofs;
  logic                           req;
  logic                           buf_acc;
  logic                           glb_wr;
  logic [capture_pkg::DATA_W-1:0] reg_rdata;

  // --------------------
  // Address decode
  // --------------------
  assign region    = capture_pkg::region_e'(wb_adr_i[capture_pkg::ADDR_W-1 -: 3]);
  assign in_window = (wb_adr_i[capture_pkg::REG_WINDOW_W+2:3] == '0);
  assign reg_ofs   = {wb_adr_i[2:1], 1'b0};
  // No new request while the previous ack is still out
  assign req       = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign buf_acc   = (region == capture_pkg::REGION_RX1) && !in_window;
  assign glb_wr    = wb_we_i && in_window && (region == capture_pkg::REGION_GLOBAL);

  assign sel_o   = wb_sel_i;
  assign wdata_o = wb_dat_i;

  // Unmapped and reserved offsets read as zero
  always_comb begin
    reg_rdata = '0;
    if (in_window) begin
      case (region)
        capture_pkg::REGION_GLOBAL: begin
          case (reg_ofs)
            capture_pkg::OFS_STATUS: reg_rdata[capture_pkg::STATUS_W-1:0] = status_i;
            capture_pkg::OFS_CNT_LO: reg_rdata = global_cnt_i[capture_pkg::DATA_W-1:0];
            capture_pkg::OFS_CNT_HI: reg_rdata = global_cnt_i[capture_pkg::TS_W-1 -: 16];
            default: ;
          endcase
        end
        capture_pkg::REGION_RX1: begin
          case (reg_ofs)
            capture_pkg::OFS_TS_LO: reg_rdata = rx_timestamp_i[capture_pkg::DATA_W-1:0];
            capture_pkg::OFS_TS_HI: reg_rdata = rx_timestamp_i[capture_pkg::TS_W-1 -: 16];
            capture_pkg::OFS_LEN:   reg_rdata[capture_pkg::LEN_W-1:0] = rx_frame_len_i;
            default: ;
          endcase
        end
        default: ;
      endcase
    end
  end

  // --------------------
  // Bus FSM
  // --------------------
  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      state       <= capture_pkg::HB_IDLE;
      wb_ack_o    <= 1'b0;
      a_we_o      <= 1'b0;
      stat_we_o   <= 1'b0;
      cnt_lo_we_o <= 1'b0;
      cnt_hi_we_o <= 1'b0;
    end else begin
      wb_ack_o    <= 1'b0;
      a_we_o      <= 1'b0;
      stat_we_o   <= 1'b0;
      cnt_lo_we_o <= 1'b0;
      cnt_hi_we_o <= 1'b0;
      case (state)
        capture_pkg::HB_IDLE: begin
          if (req) begin
            if (buf_acc && !wb_we_i) begin
              state <= capture_pkg::HB_MEM_ADDR;
            end else begin
              state       <= capture_pkg::HB_ACK;
              a_we_o      <= buf_acc && wb_we_i;
              stat_we_o   <= glb_wr && (reg_ofs == capture_pkg::OFS_STATUS);
              cnt_lo_we_o <= glb_wr && (reg_ofs == capture_pkg::OFS_CNT_LO);
              cnt_hi_we_o <= glb_wr && (reg_ofs == capture_pkg::OFS_CNT_HI);
            end
          end
        end
        capture_pkg::HB_MEM_ADDR: begin
          state <= capture_pkg::HB_MEM_WAIT;
        end
        capture_pkg::HB_MEM_WAIT: begin
          wb_ack_o <= 1'b1;
          state    <= capture_pkg::HB_IDLE;
        end
        capture_pkg::HB_ACK: begin
          wb_ack_o <= 1'b1;
          state    <= capture_pkg::HB_IDLE;
        end
        default: begin
          state <= capture_pkg::HB_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_125) begin
    if (state == capture_pkg::HB_IDLE && req) begin
      a_addr_o  <= wb_adr_i[capture_pkg::BUF_ADDR_W:1];
      a_be_o    <= wb_sel_i;
      a_wdata_o <= wb_dat_i;
    end
    if (state == capture_pkg::HB_MEM_WAIT) begin
      wb_dat_o <= a_rdata_i;
    end else if (state == capture_pkg::HB_ACK) begin
      wb_dat_o <= reg_rdata;
    end
  end

endmodule

`default_nettype wire

// ==== capture_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module capture_top (
  input  wire                            clk_125,
  input  wire                            core_rst_n,
  // Host bus
  input  wire                            wb_cyc_i,
  input  wire                            wb_stb_i,
  input  wire                            wb_we_i,
  input  wire  [capture_pkg::ADDR_W-1:0] wb_adr_i,
  input  wire  [1:0]                     wb_sel_i,
  input  wire  [capture_pkg::DATA_W-1:0] wb_dat_i,
  output logic [capture_pkg::DATA_W-1:0] wb_dat_o,
  output logic                           wb_ack_o,
  // Ethernet receive
  input  wire                            rx_dv_i,
  input  wire  [7:0]                     rx_data_i,
  output logic                           irq_o,
  output logic                           rx_busy_o
);

  logic                                armed;
  logic                                frame_done;
  logic [capture_pkg::TS_W-1:0]        global_cnt;
  logic [capture_pkg::STATUS_W-1:0]    status;
  logic                                stat_we;
  logic                                cnt_lo_we;
  logic                                cnt_hi_we;
  logic [1:0]                          reg_sel;
  logic [capture_pkg::DATA_W-1:0]      reg_wdata;
  logic [capture_pkg::TS_W-1:0]        rx_timestamp;
  logic [capture_pkg::LEN_W-1:0]       rx_frame_len;
  logic [capture_pkg::BUF_ADDR_W-1:0]  a_addr;
  logic                                a_we;
  logic [1:0]                          a_be;
  logic [capture_pkg::DATA_W-1:0]      a_wdata;
  logic [capture_pkg::DATA_W-1:0]      a_rdata;
  logic [capture_pkg::BUF_ADDR_W-1:0]  b_addr;
  logic                                b_we;
  logic [1:0]                          b_be;
  logic [capture_pkg::DATA_W-1:0]      b_wdata;

  eth_rx_capture u_rx (
    .clk_125(clk_125), .core_rst_n(core_rst_n),
    .armed_i(armed), .global_cnt_i(global_cnt),
    .rx_dv_i(rx_dv_i), .rx_data_i(rx_data_i),
    .frame_done_o(frame_done), .rx_busy_o(rx_busy_o),
    .buf_we_o(b_we), .buf_addr_o(b_addr), .buf_be_o(b_be), .buf_wdata_o(b_wdata),
    .rx_timestamp_o(rx_timestamp), .rx_frame_len_o(rx_frame_len)
  );

  frame_buffer u_buf (
    .clk_125(clk_125),
    .a_addr_i(a_addr), .a_we_i(a_we), .a_be_i(a_be), .a_wdata_i(a_wdata),
    .a_rdata_o(a_rdata),
    .b_addr_i(b_addr), .b_we_i(b_we), .b_be_i(b_be), .b_wdata_i(b_wdata)
  );

  global_regs u_regs (
    .clk_125(clk_125), .core_rst_n(core_rst_n), .frame_done_i(frame_done),
    .stat_we_i(stat_we), .cnt_lo_we_i(cnt_lo_we), .cnt_hi_we_i(cnt_hi_we),
    .sel_i(reg_sel), .wdata_i(reg_wdata),
    .status_o(status), .global_cnt_o(global_cnt), .armed_o(armed), .irq_o(irq_o)
  );

  host_bus_decoder u_bus (
    .clk_125(clk_125), .core_rst_n(core_rst_n),
    .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
    .wb_adr_i(wb_adr_i), .wb_sel_i(wb_sel_i), .wb_dat_i(wb_dat_i),
    .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
    .stat_we_o(stat_we), .cnt_lo_we_o(cnt_lo_we), .cnt_hi_we_o(cnt_hi_we),
    .sel_o(reg_sel), .wdata_o(reg_wdata),
    .status_i(status), .global_cnt_i(global_cnt),
    .rx_timestamp_i(rx_timestamp), .rx_frame_len_i(rx_frame_len),
    .a_addr_o(a_addr), .a_we_o(a_we), .a_be_o(a_be), .a_wdata_o(a_wdata),
    .a_rdata_i(a_rdata)
  );

endmodule

`default_nettype wire

// ==== tb_capture_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_capture_checker (
  input  wire         clk_125,
  input  wire         core_rst_n,
  input  wire         wb_cyc_i,
  input  wire         wb_stb_i,
  input  wire         wb_we_i,
  input  wire  [15:0] wb_adr_i,
  input  wire  [1:0]  wb_sel_i,
  input  wire  [15:0] wb_dat_i,
  input  wire  [15:0] wb_dat_o,
  input  wire         wb_ack_o,
  input  wire         rx_dv_i,
  input  wire  [7:0]  rx_data_i,
  input  wire         irq_o,
  input  wire         rx_busy_o,
  output int          check_cnt,
  output int          error_cnt
);

  localparam int M_IDLE = 0;
  localparam int M_GAP  = 1;
  localparam int M_LOAD = 2;
  localparam int M_DONE = 3;

  logic [15:0] bmem   [0:4095];
  logic        bknown [0:4095];
  logic [3:0]  m_status;
  logic [3:0]  m_status_prev;
  logic [31:0] m_cnt;
  logic [31:0] m_cnt_prev;
  logic [31:0] m_ts;
  logic [11:0] m_len;
  logic [11:0] m_bytes;
  int          m_state;

  initial begin
    check_cnt = 0;
    error_cnt = 0;
    for (int i = 0; i < 4096; i++) begin
      bknown[i] = 1'b0;
    end
  end

  function automatic logic [15:0] merge_bytes(input logic [15:0] old, input logic [15:0] dat,
                                              input logic [1:0] sel);
    return {sel[1] ? dat[15:8] : old[15:8], sel[0] ? dat[7:0] : old[7:0]};
  endfunction

  // Expected read data from the address map
  function automatic logic [15:0] expected_read(input logic [15:0] adr);
    logic [2:0] region;
    logic       in_win;
    logic [2:0] ofs;
    region = adr[15:13];
    in_win = (adr[12:3] == 10'd0);
    ofs    = {adr[2:1], 1'b0};
    if (region == 3'd4 && !in_win) return bmem[adr[12:1]];
    if (!in_win) return 16'h0000;
    if (region == 3'd0 && ofs == 3'd0) return {12'h000, m_status_prev};
    if (region == 3'd0 && ofs == 3'd2) return m_cnt_prev[15:0];
    if (region == 3'd0 && ofs == 3'd4) return m_cnt_prev[31:16];
    if (region == 3'd4 && ofs == 3'd0) return m_ts[15:0];
    if (region == 3'd4 && ofs == 3'd2) return m_ts[31:16];
    if (region == 3'd4 && ofs == 3'd4) return {4'h0, m_len};
    return 16'h0000;
  endfunction

  always @(posedge clk_125) begin : watch
    logic [3:0]  stat_now;
    logic [31:0] loaded;
    logic        cnt_wr;
    logic        glb;
    logic [11:0] w;
    cnt_wr = 1'b0;
    loaded = m_cnt_prev;
    glb    = (wb_adr_i[15:13] == 3'd0) && (wb_adr_i[12:3] == 10'd0);
    w      = wb_adr_i[12:1];
    if (!core_rst_n) begin
      m_status      = '0;
      m_status_prev = '0;
      m_cnt         = '0;
      m_cnt_prev    = '0;
      m_ts          = '0;
      m_len         = '0;
      m_bytes       = '0;
      m_state       = M_IDLE;
    end else begin
      if (wb_cyc_i && wb_stb_i && wb_ack_o) begin
        if (wb_we_i) begin
          if (glb && wb_adr_i[2:1] == 2'd0 && wb_sel_i[0]) m_status = wb_dat_i[3:0];
          if (glb && wb_adr_i[2:1] == 2'd1) begin
            loaded[15:0] = merge_bytes(m_cnt_prev[15:0], wb_dat_i, wb_sel_i);
            cnt_wr       = 1'b1;
          end
          if (glb && wb_adr_i[2:1] == 2'd2) begin
            loaded[31:16] = merge_bytes(m_cnt_prev[31:16], wb_dat_i, wb_sel_i);
            cnt_wr        = 1'b1;
          end
          if (wb_adr_i[15:13] == 3'd4 && wb_adr_i[12:3] != 10'd0) begin
            bmem[w]   = merge_bytes(bmem[w], wb_dat_i, wb_sel_i);
            bknown[w] = 1'b1;
          end
        end else if (!(wb_adr_i[15:13] == 3'd4 && wb_adr_i[12:3] != 10'd0) || bknown[w]) begin
          check_cnt++;
          if (wb_dat_o !== expected_read(wb_adr_i)) begin
            $display("[ERROR] %0t: read of %h returned %h, expected %h",
                     $time, wb_adr_i, wb_dat_o, expected_read(wb_adr_i));
            error_cnt++;
          end
        end
      end
      stat_now = m_status;
      if (irq_o !== m_status[0] || rx_busy_o !== (m_state == M_LOAD)) begin
        $display("[ERROR] %0t: irq_o=%b rx_busy_o=%b, expected %b %b",
                 $time, irq_o, rx_busy_o, m_status[0], m_state == M_LOAD);
        error_cnt++;
      end
      // Receiver model
      case (m_state)
        M_IDLE: begin
          m_bytes = '0;
          if (m_status[1]) m_state = M_GAP;
        end
        M_GAP: begin
          if (!m_status[1]) m_state = M_IDLE;
          else if (!rx_dv_i) m_state = M_LOAD;
        end
        M_LOAD: begin
          if (rx_dv_i) begin
            if (m_bytes == 12'd0) m_ts = m_cnt;
            w = capture_pkg::BUF_BASE_WORD + {1'b0, m_bytes[11:1]};
            if (m_bytes[0]) bmem[w][15:8] = rx_data_i;
            else bmem[w][7:0] = rx_data_i;
            bknown[w] = 1'b1;
            m_bytes++;
          end else if (m_bytes != 12'd0) begin
            m_state = M_DONE;
          end
        end
        default: begin
          m_len       = m_bytes;
          m_status[0] = 1'b1;
          m_status[1] = 1'b0;
          m_state     = M_IDLE;
        end
      endcase
      m_status_prev = stat_now;
      if (cnt_wr) begin
        m_cnt_prev = loaded;
        m_cnt      = loaded + 32'd1;
      end else begin
        m_cnt_prev = m_cnt;
        m_cnt      = m_cnt + 32'd1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_capture_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_capture_top;

  logic        clk_125;
  logic        core_rst_n;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic [15:0] wb_adr_i;
  logic [1:0]  wb_sel_i;
  logic [15:0] wb_dat_i;
  logic [15:0] wb_dat_o;
  logic        wb_ack_o;
  logic        rx_dv_i;
  logic [7:0]  rx_data_i;
  logic        irq_o;
  logic        rx_busy_o;
  logic [31:0] lfsr_state;
  logic [31:0] r;
  int          check_cnt;
  int          error_cnt;
  int          timeouts;
  int          len;

  capture_top uut (
    .clk_125(clk_125), .core_rst_n(core_rst_n),
    .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i),
    .wb_sel_i(wb_sel_i), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
    .rx_dv_i(rx_dv_i), .rx_data_i(rx_data_i), .irq_o(irq_o), .rx_busy_o(rx_busy_o)
  );

  tb_capture_checker u_chk (
    .clk_125(clk_125), .core_rst_n(core_rst_n),
    .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i),
    .wb_sel_i(wb_sel_i), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
    .rx_dv_i(rx_dv_i), .rx_data_i(rx_data_i), .irq_o(irq_o), .rx_busy_o(rx_busy_o),
    .check_cnt(check_cnt), .error_cnt(error_cnt)
  );

  always #5 clk_125 = ~clk_125;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic get_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [15:0] reg_adr(input logic [2:0] region, input logic [2:0] ofs);
    return {region, 10'd0, ofs};
  endfunction

  function automatic logic [15:0] buf_adr(input logic [11:0] word);
    return {3'd4, word[11:0], 1'b0};
  endfunction

  task automatic bus_cycle(input logic we, input logic [15:0] adr, input logic [1:0] sel,
                           input logic [15:0] dat);
    int  n;
    logic got;
    n   = 0;
    got = 1'b0;
    @(posedge clk_125);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_sel_i <= sel;
    wb_dat_i <= dat;
    while (!got && n < 40) begin
      @(posedge clk_125);
      n++;
      if (wb_ack_o) got = 1'b1;
    end
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
    if (!got) begin
      timeouts++;
      $display("Timeout: no bus acknowledge for address %h", adr);
    end
  endtask

  task automatic send_frame(input int nbytes);
    logic [31:0] v;
    for (int i = 0; i < nbytes; i++) begin
      get_bits(8, v);
      @(posedge clk_125);
      rx_dv_i   <= 1'b1;
      rx_data_i <= v[7:0];
    end
    @(posedge clk_125);
    rx_dv_i <= 1'b0;
    get_bits(3, v);
    repeat (int'(v[2:0]) + 1) @(posedge clk_125);
  endtask

  task automatic wait_irq();
    int n;
    n = 0;
    while (!irq_o && n < 300) begin
      @(posedge clk_125);
      n++;
    end
    if (!irq_o) begin
      timeouts++;
      $display("Timeout: interrupt never rose after a frame");
    end
  endtask

  // Slot registers followed by every captured word
  task automatic read_slot(input int nbytes);
    bus_cycle(1'b0, reg_adr(3'd0, 3'd0), 2'b11, 16'h0);
    bus_cycle(1'b0, reg_adr(3'd4, 3'd0), 2'b11, 16'h0);
    bus_cycle(1'b0, reg_adr(3'd4, 3'd2), 2'b11, 16'h0);
    bus_cycle(1'b0, reg_adr(3'd4, 3'd4), 2'b11, 16'h0);
    for (int i = 0; i < (nbytes + 1) / 2; i++) begin
      bus_cycle(1'b0, buf_adr(12'd8 + 12'(i)), 2'b11, 16'h0);
    end
  endtask

  initial begin
    clk_125    = 1'b0;
    core_rst_n = 1'b0;
    wb_cyc_i   = 1'b0;
    wb_stb_i   = 1'b0;
    wb_we_i    = 1'b0;
    wb_adr_i   = '0;
    wb_sel_i   = '0;
    wb_dat_i   = '0;
    rx_dv_i    = 1'b0;
    rx_data_i  = '0;
    lfsr_state = 32'hb2b0;
    timeouts   = 0;
    repeat (3) @(posedge clk_125);
    core_rst_n <= 1'b1;
    @(posedge clk_125);

    bus_cycle(1'b0, reg_adr(3'd0, 3'd0), 2'b11, 16'h0);
    bus_cycle(1'b0, reg_adr(3'd0, 3'd2), 2'b11, 16'h0);
    bus_cycle(1'b0, reg_adr(3'd0, 3'd2), 2'b11, 16'h0);

    // --------------------
    // Armed captures
    // --------------------
    for (int f = 0; f < 6; f++) begin
      bus_cycle(1'b1, reg_adr(3'd0, 3'd0), 2'b01, 16'h0002);
      repeat (4) @(posedge clk_125);
      bus_cycle(1'b0, reg_adr(3'd0, 3'd2), 2'b11, 16'h0);
      get_bits(6, r);
      len = int'(r[5:0]) + 1;
      send_frame(len);
      wait_irq();
      bus_cycle(1'b0, reg_adr(3'd0, 3'd2), 2'b11, 16'h0);
      read_slot(len);
      bus_cycle(1'b1, reg_adr(3'd0, 3'd0), 2'b01, 16'h0000);
    end

    // --------------------
    // Unarmed and mid-frame arming
    // --------------------
    send_frame(20);
    read_slot(20);
    fork
      send_frame(60);
      begin
        repeat (10) @(posedge clk_125);
        bus_cycle(1'b1, reg_adr(3'd0, 3'd0), 2'b01, 16'h0002);
      end
    join
    read_slot(60);
    repeat (3) @(posedge clk_125);
    send_frame(33);
    wait_irq();
    read_slot(60);
    bus_cycle(1'b1, reg_adr(3'd0, 3'd0), 2'b01, 16'h0000);

    // --------------------
    // Host writes
    // --------------------
    for (int i = 0; i < 8; i++) begin
      get_bits(8, r);
      len = 1000 + int'(r[7:0]);
      get_bits(16, r);
      bus_cycle(1'b1, buf_adr(12'(len)), 2'b11, r[15:0]);
      get_bits(18, r);
      bus_cycle(1'b1, buf_adr(12'(len)), r[17:16], r[15:0]);
      bus_cycle(1'b0, buf_adr(12'(len)), 2'b11, 16'h0);
      get_bits(18, r);
      bus_cycle(1'b1, reg_adr(3'd0, i[0] ? 3'd4 : 3'd2), r[17:16], r[15:0]);
      bus_cycle(1'b0, reg_adr(3'd0, i[0] ? 3'd4 : 3'd2), 2'b11, 16'h0);
    end

    // --------------------
    // Unmapped and reserved
    // --------------------
    bus_cycle(1'b0, 16'h2000, 2'b11, 16'h0);
    bus_cycle(1'b0, 16'h4002, 2'b11, 16'h0);
    bus_cycle(1'b0, 16'hA004, 2'b11, 16'h0);
    bus_cycle(1'b0, 16'hE000, 2'b11, 16'h0);
    bus_cycle(1'b0, 16'h0006, 2'b11, 16'h0);
    bus_cycle(1'b0, 16'h8006, 2'b11, 16'h0);
    bus_cycle(1'b0, 16'h0100, 2'b11, 16'h0);

    repeat (5) @(posedge clk_125);
    $display("Checks: %0d  errors: %0d  timeouts: %0d", check_cnt, error_cnt, timeouts);
    if (error_cnt == 0 && timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== capture_top.f ====
capture_pkg.sv
eth_rx_capture.sv
frame_buffer.sv
global_regs.sv
host_bus_decoder.sv
capture_top.sv
tb_capture_checker.sv
tb_capture_top.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_capture_top -f capture_top.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
if grep -q "Test failures found" sim.log; then
  exit 1
fi
